// ==== Bender.yml ====
package:
  name: rv32i_back_end

sources:
  - include_dirs:
      - source
    files:
      - source/rv32i_pkg.sv
      - source/pipe_reg.sv
      - source/exe_stage.sv
      - source/mem_stage.sv
      - source/writeback_stage.sv
      - source/stage_ctrl.sv
      - source/rv32i_back_end.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/back_end_tb.sv

// ==== bench/back_end_tb.sv ====
// directed testbench for the RV32I back end with data-memory and register-file models
`include "rv32i_settings.svh"

module back_end_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv32i_pkg::*;

    logic clk, rst, issue_i, ready_o;
    issue_bundle_t issue_bundle_i;
    logic dmem_req_o, dmem_we_o, dmem_resp_i;
    logic [`RV_XLEN-1:0] dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic [`RV_XLEN/8-1:0] dmem_be_o;
    logic branch_o, rf_we_o;
    logic [`RV_XLEN-1:0] branch_target_o, rf_wdata_o;
    logic [`RV_REG_W-1:0] rf_rd_o;

    logic [`RV_XLEN-1:0] rf_model [32];  // written only from the DUT write port
    logic [`RV_XLEN-1:0] exp_rf [32];    // architectural expectation
    logic [`RV_XLEN-1:0] mem [256];
    logic [`RV_REG_W-1:0] got_rd_q[$], exp_rd_q[$];
    logic [`RV_XLEN-1:0] got_data_q[$], exp_data_q[$];
    int got_cyc_q[$], exp_cyc_q[$];
    int cycle;
    logic held;
    logic [`RV_XLEN-1:0] held_addr;
    logic [`RV_XLEN/8-1:0] held_be;
    int delay;

    rv32i_back_end rv32i_back_end_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped after the first failure");
    endtask

    task automatic value_error(input string msg);
        fail_now($sformatf("ERROR @%0t: %s", $time, msg));
    endtask

    // reference rules straight from the RV32I spec
    function automatic logic [`RV_XLEN-1:0] alu_ref(alu_op_e op, logic [`RV_XLEN-1:0] a,
                                                    logic [`RV_XLEN-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic cmp_ref(cmp_op_e op, logic [`RV_XLEN-1:0] a,
                                     logic [`RV_XLEN-1:0] b);
        case (op)
            cmp_beq:  return a == b;
            cmp_bne:  return a != b;
            cmp_blt:  return $signed(a) < $signed(b);
            cmp_bge:  return $signed(a) >= $signed(b);
            cmp_bltu: return a < b;
            cmp_bgeu: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic logic [`RV_XLEN-1:0] load_ref(logic [`RV_XLEN-1:0] word, mem_size_e sz,
                                                     logic uns, logic [1:0] off);
        logic [`RV_XLEN-1:0] sh;
        sh = word >> (8 * off);
        case (sz)
            mem_byte: return uns ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            mem_half: return uns ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default:  return sh;
        endcase
    endfunction

    // bundle carries whatever the register-file model holds right now
    function automatic issue_bundle_t make_bundle(alu_op_e op, logic [4:0] rd, logic [4:0] rs1,
                                                  logic [4:0] rs2, logic [`RV_XLEN-1:0] imm,
                                                  opb_sel_e sel);
        issue_bundle_t b;
        b = '0;
        b.pc = `RV_RESET_PC + 32'h100;
        b.rs1_idx = rs1;
        b.rs1_data = rf_model[rs1];
        b.rs2_idx = rs2;
        b.rs2_data = rf_model[rs2];
        b.imm = imm;
        b.alu_op = op;
        b.opb_sel = sel;
        b.cmp_op = cmp_none;
        b.cw_wb = '{regf_we: 1'b1, rd: rd, rf_sel: rf_alu_out};
        return b;
    endfunction

    task automatic check_wb(input logic [`RV_REG_W-1:0] exp_rd, input logic [`RV_XLEN-1:0] exp_d,
                            input logic [`RV_REG_W-1:0] got_rd, input logic [`RV_XLEN-1:0] got_d);
        if (exp_rd !== got_rd || exp_d !== got_d)
            value_error($sformatf("writeback x%0d=%h, expected x%0d=%h",
                                  got_rd, got_d, exp_rd, exp_d));
    endtask

    task automatic check_branch(input logic exp_taken, input logic [`RV_XLEN-1:0] exp_target);
        if (branch_o !== exp_taken)
            value_error($sformatf("branch_o %b, expected %b", branch_o, exp_taken));
        if (exp_taken && branch_target_o !== exp_target)
            value_error($sformatf("branch target %h, expected %h", branch_target_o, exp_target));
    endtask

    task automatic check_req(input logic exp_we, input logic [`RV_XLEN-1:0] exp_addr,
                             input logic [`RV_XLEN/8-1:0] exp_be, input logic [`RV_XLEN-1:0] exp_wd);
        logic [`RV_XLEN-1:0] mask;
        mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
        if (dmem_we_o !== exp_we || dmem_addr_o !== exp_addr || dmem_be_o !== exp_be)
            value_error($sformatf("request we=%b addr=%h be=%b, expected we=%b addr=%h be=%b",
                                  dmem_we_o, dmem_addr_o, dmem_be_o, exp_we, exp_addr, exp_be));
        if (exp_we && (dmem_wdata_o & mask) !== (exp_wd & mask))
            value_error($sformatf("store lanes %h, expected %h",
                                  dmem_wdata_o & mask, exp_wd & mask));
    endtask

    task automatic issue(input issue_bundle_t b, output int acc);
        int t;
        issue_bundle_i = b;
        issue_i = 1'b1;
        t = 0;
        @(posedge clk);
        while (!ready_o) begin
            t++;
            if (t > 30) fail_now("instruction not accepted within 30 cycles");
            @(posedge clk);
        end
        acc = cycle;
        #1;
        issue_i = 1'b0;
    endtask

    task automatic expect_wb(input logic [4:0] rd, input logic [`RV_XLEN-1:0] d, input int cyc);
        if (rd != 0) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(d);
            exp_cyc_q.push_back(cyc);
            exp_rf[rd] = d;
        end
    endtask

    task automatic drain();
        int t;
        int ec, gc;
        while (exp_rd_q.size() > 0) begin
            t = 0;
            while (got_rd_q.size() == 0) begin
                t++;
                if (t > 40) fail_now("expected writeback did not arrive within 40 cycles");
                @(posedge clk);
                #1;
            end
            ec = exp_cyc_q.pop_front();
            gc = got_cyc_q.pop_front();
            check_wb(exp_rd_q.pop_front(), exp_data_q.pop_front(), got_rd_q.pop_front(),
                     got_data_q.pop_front());
            if (ec >= 0 && gc != ec)
                value_error($sformatf("writeback in cycle %0d, expected cycle %0d", gc, ec));
        end
    endtask

    task automatic run_alu(input alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [`RV_XLEN-1:0] imm,
                           input opb_sel_e sel);
        logic [`RV_XLEN-1:0] res;
        int acc;
        res = alu_ref(op, exp_rf[rs1], (sel == opb_imm) ? imm : exp_rf[rs2]);
        issue(make_bundle(op, rd, rs1, rs2, imm, sel), acc);
        expect_wb(rd, res, acc + 2);
    endtask

    // LUI when use_pc is low and a JAL-style link value otherwise
    task automatic run_upper(input logic [4:0] rd, input logic use_pc,
                             input logic [`RV_XLEN-1:0] val);
        issue_bundle_t b;
        int acc;
        b = make_bundle(alu_add, rd, 0, 0, 0, opb_imm);
        b.u_imm = val;
        b.pc = val;
        b.cw_wb.rf_sel = use_pc ? rf_pc_plus4 : rf_u_imm;
        issue(b, acc);
        expect_wb(rd, use_pc ? val + 4 : val, acc + 2);
    endtask

    task automatic run_branch(input cmp_op_e op, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [`RV_XLEN-1:0] imm);
        issue_bundle_t b;
        int acc;
        b = make_bundle(alu_add, 0, rs1, rs2, imm, opb_rs2);
        b.cmp_op = op;
        b.cw_wb = '0;
        issue(b, acc);
        @(posedge clk);
        check_branch(cmp_ref(op, exp_rf[rs1], exp_rf[rs2]), b.pc + imm);
        #1;
    endtask

    task automatic run_mem(input logic st, input mem_size_e sz, input logic uns,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [`RV_XLEN-1:0] imm, input logic wait_done);
        issue_bundle_t b;
        logic [`RV_XLEN-1:0] addr, ld;
        logic [`RV_XLEN/8-1:0] be;
        int acc, t;
        addr = exp_rf[rs1] + imm;
        be = (sz == mem_byte) ? 4'b0001 << addr[1:0] :
             (sz == mem_half) ? 4'b0011 << addr[1:0] : 4'b1111;
        ld = load_ref(mem[addr[9:2]], sz, uns, addr[1:0]);
        b = make_bundle(alu_add, rd, rs1, rs2, imm, opb_imm);
        b.cw_mem = '{read: !st, write: st, size: sz, uns: uns};
        b.cw_wb = '{regf_we: !st, rd: rd, rf_sel: rf_mem_rdata};
        issue(b, acc);
        t = 0;
        while (!dmem_req_o) begin
            t++;
            if (t > 10) fail_now("no memory request after a load or store");
            @(posedge clk);
            #1;
        end
        check_req(st, {addr[31:2], 2'b00}, be, exp_rf[rs2] << (8 * addr[1:0]));
        if (!st) expect_wb(rd, ld, -1);   // latency set by the memory
        if (wait_done) begin
            t = 0;
            do begin
                t++;
                if (t > 10) fail_now("memory response never arrived");
                @(posedge clk);
            end while (!dmem_resp_i);
            #1;
            drain();
        end
    endtask

    // data memory model answering after 1 to 4 cycles
    initial begin
        void'($urandom(31));
        forever begin
            @(posedge clk);
            if (dmem_req_o && !dmem_resp_i) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                #1;
                dmem_rdata_i = mem[dmem_addr_o[9:2]];
                for (int k = 0; k < 4; k++)
                    if (dmem_we_o && dmem_be_o[k])
                        mem[dmem_addr_o[9:2]][8*k +: 8] = dmem_wdata_o[8*k +: 8];
                dmem_resp_i = 1'b1;
                @(posedge clk);
                #1 dmem_resp_i = 1'b0;
            end
        end
    end

    // write port and stall monitor
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst) begin
            if (rf_we_o && rf_rd_o == '0) fail_now("write enable raised for x0");
            if (rf_we_o) begin
                rf_model[rf_rd_o] = rf_wdata_o;
                got_rd_q.push_back(rf_rd_o);
                got_data_q.push_back(rf_wdata_o);
                got_cyc_q.push_back(cycle);
            end
            if (dmem_req_o && !dmem_resp_i && ready_o) fail_now("ready_o high during a memory access");
            if (held && (!dmem_req_o || dmem_addr_o !== held_addr || dmem_be_o !== held_be))
                fail_now("memory request changed before its response");
        end
        held = dmem_req_o && !dmem_resp_i;
        held_addr = dmem_addr_o;
        held_be = dmem_be_o;
    end

    initial begin
        alu_op_e ops[10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                             alu_xor, alu_srl, alu_sra, alu_or, alu_and};
        rst = 1'b1;
        issue_i = 1'b0;
        issue_bundle_i = '0;
        dmem_resp_i = 1'b0;
        dmem_rdata_i = '0;
        cycle = 0;
        held = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
            exp_rf[i] = '0;
        end
        for (int i = 0; i < 256; i++) mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, i[7:0] + 8'hC3};
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        // ALU ops on register and immediate operands
        run_alu(alu_add, 1, 0, 0, 32'd100, opb_imm);
        run_alu(alu_add, 2, 0, 0, 32'hFFFF_FFF9, opb_imm);
        for (int i = 0; i < 10; i++) run_alu(ops[i], 3 + i, 1, 2, 0, opb_rs2);
        for (int i = 0; i < 10; i++) run_alu(ops[i], 13 + i, 2, 0, 32'd5 + i, opb_imm);
        drain();

        // dependent chain at distance 1 and 2 plus a write to x0
        run_alu(alu_add, 1, 0, 0, 32'd5, opb_imm);
        run_alu(alu_add, 2, 1, 1, 0, opb_rs2);
        run_alu(alu_add, 3, 1, 2, 0, opb_rs2);
        run_alu(alu_add, 0, 3, 0, 32'd1, opb_imm);
        run_alu(alu_xor, 4, 3, 2, 0, opb_rs2);
        run_alu(alu_sub, 5, 4, 1, 0, opb_rs2);
        run_alu(alu_add, 6, 0, 0, 32'hFFFF_FFFD, opb_imm);
        drain();

        // branches
        run_branch(cmp_beq, 1, 1, 32'h40);
        run_branch(cmp_beq, 1, 2, 32'h40);
        run_branch(cmp_bne, 1, 2, 32'hFFFF_FFF0);
        run_branch(cmp_blt, 6, 1, 32'h8);
        run_branch(cmp_bge, 6, 1, 32'h8);
        run_branch(cmp_bltu, 6, 1, 32'h10);
        run_branch(cmp_bgeu, 6, 1, 32'h10);
        run_branch(cmp_none, 1, 1, 32'h10);

        // stores at every offset then loads back
        run_alu(alu_add, 10, 0, 0, 32'h100, opb_imm);
        run_upper(11, 1'b0, 32'h8BAD_F000);
        run_alu(alu_or, 11, 11, 0, 32'h0000_0E8D, opb_imm);
        drain();
        for (int o = 0; o < 4; o++) run_mem(1'b1, mem_byte, 1'b0, 0, 10, 11, o, 1'b1);
        for (int o = 0; o < 4; o += 2) run_mem(1'b1, mem_half, 1'b0, 0, 10, 11, 8 + o, 1'b1);
        run_mem(1'b1, mem_word, 1'b0, 0, 10, 11, 32'h10, 1'b1);
        for (int o = 0; o < 4; o++) begin
            run_mem(1'b0, mem_byte, 1'b0, 12, 10, 0, 8 + o, 1'b1);
            run_mem(1'b0, mem_byte, 1'b1, 13, 10, 0, 8 + o, 1'b1);
        end
        for (int o = 0; o < 4; o += 2) begin
            run_mem(1'b0, mem_half, 1'b0, 14, 10, 0, o, 1'b1);
            run_mem(1'b0, mem_half, 1'b1, 15, 10, 0, 32'h10 + o, 1'b1);
        end
        run_mem(1'b0, mem_word, 1'b0, 16, 10, 0, 32'h10, 1'b1);

        // issue held off by a load stall before LUI and link values
        for (int n = 0; n < 4; n++) begin
            run_mem(1'b0, mem_word, 1'b0, 17, 10, 0, 32'h20 + 4 * n, 1'b0);
            run_upper(18, 1'b0, 32'h1234_5000 + n);
            run_upper(19, 1'b1, 32'h4000_0400 + 8 * n);
            drain();
        end

        repeat (3) @(posedge clk);
        #1;
        if (got_rd_q.size() != 0) begin
            fail_now("unexpected extra register writes");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule : back_end_tb

// ==== source/exe_stage.sv ====
// execute stage, forwards operands and computes ALU result, branch compare and target
`include "rv32i_settings.svh"

module exe_stage (
    input  rv32i_pkg::issue_bundle_t issue_bundle_i,
    input  rv32i_pkg::exe_mem_t      exmem_fwd_i,    // EX/MEM contents
    input  logic [`RV_XLEN-1:0]      wb_fwd_data_i,
    input  rv32i_pkg::cw_wb_t        wb_fwd_cw_i,
    output rv32i_pkg::exe_mem_t      exe_o,
    output logic [`RV_XLEN-1:0]      branch_target_o
);
    import rv32i_pkg::*;

    logic [`RV_XLEN-1:0] exmem_val;
    logic                exmem_ok, wb_ok;
    logic [`RV_XLEN-1:0] rs1, rs2, opb;
    logic [`RV_XLEN-1:0] alu_res, target;
    logic [4:0]          shamt;
    logic                br_en;

    // what EX/MEM is going to write, a load has no data yet
    always_comb begin
        case (exmem_fwd_i.cw_wb.rf_sel)
            rf_u_imm:    exmem_val = exmem_fwd_i.u_imm;
            rf_pc_plus4: exmem_val = exmem_fwd_i.pc + `RV_XLEN'd4;
            default:     exmem_val = exmem_fwd_i.alu;
        endcase
    end

    assign exmem_ok = exmem_fwd_i.cw_wb.regf_we && (exmem_fwd_i.cw_wb.rd != '0)
                   && (exmem_fwd_i.cw_wb.rf_sel != rf_mem_rdata);
    assign wb_ok    = wb_fwd_cw_i.regf_we && (wb_fwd_cw_i.rd != '0);

    // EX/MEM is younger so it wins over MEM/WB
    assign rs1 = (exmem_ok && exmem_fwd_i.cw_wb.rd == issue_bundle_i.rs1_idx) ? exmem_val :
                 (wb_ok && wb_fwd_cw_i.rd == issue_bundle_i.rs1_idx) ? wb_fwd_data_i :
                 issue_bundle_i.rs1_data;
    assign rs2 = (exmem_ok && exmem_fwd_i.cw_wb.rd == issue_bundle_i.rs2_idx) ? exmem_val :
                 (wb_ok && wb_fwd_cw_i.rd == issue_bundle_i.rs2_idx) ? wb_fwd_data_i :
                 issue_bundle_i.rs2_data;

    assign opb   = (issue_bundle_i.opb_sel == opb_imm) ? issue_bundle_i.imm : rs2;
    assign shamt = opb[4:0];

    always_comb begin
        case (issue_bundle_i.alu_op)
            alu_sub:  alu_res = rs1 - opb;
            alu_sll:  alu_res = rs1 << shamt;
            alu_slt:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(rs1) < $signed(opb)};
            alu_sltu: alu_res = {{(`RV_XLEN-1){1'b0}}, rs1 < opb};
            alu_xor:  alu_res = rs1 ^ opb;
            alu_srl:  alu_res = rs1 >> shamt;
            alu_sra:  alu_res = $signed(rs1) >>> shamt;
            alu_or:   alu_res = rs1 | opb;
            alu_and:  alu_res = rs1 & opb;
            default:  alu_res = rs1 + opb;
        endcase
    end

    always_comb begin
        case (issue_bundle_i.cmp_op)
            cmp_beq:  br_en = (rs1 == rs2);
            cmp_bne:  br_en = (rs1 != rs2);
            cmp_blt:  br_en = ($signed(rs1) < $signed(rs2));
            cmp_bge:  br_en = ($signed(rs1) >= $signed(rs2));
            cmp_bltu: br_en = (rs1 < rs2);
            cmp_bgeu: br_en = (rs1 >= rs2);
            default:  br_en = 1'b0;
        endcase
    end

    assign target = issue_bundle_i.pc + issue_bundle_i.imm;

    always_comb begin
        exe_o.alu      = (issue_bundle_i.cmp_op != cmp_none) ? target : alu_res;
        exe_o.rs2_data = rs2;  // store data, forwarded too
        exe_o.pc       = issue_bundle_i.pc;
        exe_o.u_imm    = issue_bundle_i.u_imm;
        exe_o.br_en    = br_en;
        exe_o.cw_mem   = issue_bundle_i.cw_mem;
        exe_o.cw_wb    = issue_bundle_i.cw_wb;
    end

    // target rides in the alu slot, so it lines up with branch_o one cycle later
    assign branch_target_o = exmem_fwd_i.alu;

endmodule : exe_stage

// ==== source/mem_stage.sv ====
// memory stage, drives the data-memory port and aligns load data into the MEM/WB payload
`include "rv32i_settings.svh"

module mem_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     go_i,          // EX/MEM load strobe
    input  rv32i_pkg::exe_mem_t      exmem_i,
    output logic                     dmem_req_o,
    output logic                     dmem_we_o,
    output logic [`RV_XLEN-1:0]      dmem_addr_o,
    output logic [`RV_XLEN/8-1:0]    dmem_be_o,
    output logic [`RV_XLEN-1:0]      dmem_wdata_o,
    input  logic                     dmem_resp_i,
    input  logic [`RV_XLEN-1:0]      dmem_rdata_i,
    output logic                     mem_busy_o,
    output rv32i_pkg::mem_wb_t       memwb_o
);
    import rv32i_pkg::*;

    logic                acc_q;   // EX/MEM loaded at the last edge
    logic                busy_q;
    logic [1:0]          off;
    logic [`RV_XLEN-1:0] shifted, ld_data;

    assign off = exmem_i.alu[1:0];

    assign dmem_req_o = (acc_q & (exmem_i.cw_mem.read | exmem_i.cw_mem.write)) | busy_q;
    assign mem_busy_o = dmem_req_o & ~dmem_resp_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc_q  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            acc_q  <= go_i;
            busy_q <= mem_busy_o;   // held until the response
        end
    end

    assign dmem_we_o    = dmem_req_o & exmem_i.cw_mem.write;
    assign dmem_addr_o  = {exmem_i.alu[`RV_XLEN-1:2], 2'b00};
    assign dmem_wdata_o = exmem_i.rs2_data << {off, 3'b000};

    always_comb begin
        case (exmem_i.cw_mem.size)
            mem_byte: dmem_be_o = 4'b0001 << off;
            mem_half: dmem_be_o = 4'b0011 << off;
            default:  dmem_be_o = 4'b1111;
        endcase
    end

    // bring the addressed lane down to bit 0, then extend
    assign shifted = dmem_rdata_i >> {off, 3'b000};

    always_comb begin
        case (exmem_i.cw_mem.size)
            mem_byte: ld_data = {{24{shifted[7] & ~exmem_i.cw_mem.uns}}, shifted[7:0]};
            mem_half: ld_data = {{16{shifted[15] & ~exmem_i.cw_mem.uns}}, shifted[15:0]};
            default:  ld_data = shifted;
        endcase
    end

    always_comb begin
        memwb_o.alu   = exmem_i.alu;
        memwb_o.rdata = ld_data;
        memwb_o.pc    = exmem_i.pc;
        memwb_o.u_imm = exmem_i.u_imm;
        memwb_o.cw_wb = exmem_i.cw_wb;
    end

    a_addr_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_busy_o |=> dmem_req_o && $stable(dmem_addr_o)
    );

endmodule : mem_stage

// ==== source/pipe_reg.sv ====
// pipeline register between two stages, loads on go and holds otherwise, any payload type
module pipe_reg #(
    parameter type payload_t = logic,
    parameter payload_t rst_val = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     go_i,      // from stage_ctrl
    input  payload_t data_i,
    output payload_t data_o,
    output logic     rdy_o
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            data_o <= rst_val;
        end else if (go_i) begin
            data_o <= data_i;
        end
    end

    // stays high once the first go has passed
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rdy_o <= 1'b0;
        end else begin
            rdy_o <= rdy_o | go_i;
        end
    end

    a_hold_without_go: assert property (
        @(posedge clk) disable iff (rst)
        !go_i |=> $stable(data_o)
    );

endmodule : pipe_reg

// ==== source/rv32i_back_end.sv ====
// RV32I back end top, execute, memory and writeback stages with their pipeline registers
`include "rv32i_settings.svh"

module rv32i_back_end (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_i,
    input  rv32i_pkg::issue_bundle_t issue_bundle_i,
    output logic                     ready_o,
    output logic                     dmem_req_o,
    output logic                     dmem_we_o,
    output logic [`RV_XLEN-1:0]      dmem_addr_o,
    output logic [`RV_XLEN/8-1:0]    dmem_be_o,
    output logic [`RV_XLEN-1:0]      dmem_wdata_o,
    input  logic                     dmem_resp_i,
    input  logic [`RV_XLEN-1:0]      dmem_rdata_i,
    output logic                     branch_o,
    output logic [`RV_XLEN-1:0]      branch_target_o,
    output logic                     rf_we_o,
    output logic [`RV_REG_W-1:0]     rf_rd_o,
    output logic [`RV_XLEN-1:0]      rf_wdata_o
);
    import rv32i_pkg::*;

    exe_mem_t            exe_d, exmem_q;
    mem_wb_t             memwb_d, memwb_q;
    logic [`RV_XLEN-1:0] wb_fwd_data;
    cw_wb_t              wb_fwd_cw;
    logic                exe_go, mem_go, mem_busy;

    exe_stage exe_stage_i (
        .issue_bundle_i  (issue_bundle_i),
        .exmem_fwd_i     (exmem_q),
        .wb_fwd_data_i   (wb_fwd_data),
        .wb_fwd_cw_i     (wb_fwd_cw),
        .exe_o           (exe_d),
        .branch_target_o (branch_target_o)
    );

    pipe_reg #(.payload_t(exe_mem_t), .rst_val(exe_mem_rst)) exmem_reg_i (
        .clk (clk), .rst (rst), .go_i (exe_go), .data_i (exe_d), .data_o (exmem_q), .rdy_o ()
    );

    mem_stage mem_stage_i (
        .clk          (clk),
        .rst          (rst),
        .go_i         (exe_go),
        .exmem_i      (exmem_q),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_resp_i  (dmem_resp_i),
        .dmem_rdata_i (dmem_rdata_i),
        .mem_busy_o   (mem_busy),
        .memwb_o      (memwb_d)
    );

    pipe_reg #(.payload_t(mem_wb_t), .rst_val(mem_wb_rst)) memwb_reg_i (
        .clk (clk), .rst (rst), .go_i (mem_go), .data_i (memwb_d), .data_o (memwb_q), .rdy_o ()
    );

    writeback_stage writeback_stage_i (
        .clk        (clk),
        .rst        (rst),
        .go_i       (mem_go),
        .memwb_i    (memwb_q),
        .rf_we_o    (rf_we_o),
        .rf_rd_o    (rf_rd_o),
        .rf_wdata_o (rf_wdata_o),
        .fwd_data_o (wb_fwd_data),
        .fwd_cw_o   (wb_fwd_cw)
    );

    stage_ctrl stage_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .issue_i     (issue_i),
        .mem_busy_i  (mem_busy),
        .dmem_resp_i (dmem_resp_i),
        .br_en_i     (exmem_q.br_en),
        .exe_go_o    (exe_go),
        .mem_go_o    (mem_go),
        .branch_o    (branch_o),
        .ready_o     (ready_o)
    );

endmodule : rv32i_back_end

// ==== source/rv32i_pkg.sv ====
// types shared by the RV32I back-end stages: enums, control words, stage payloads
`include "rv32i_settings.svh"

package rv32i_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        cmp_none, cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu
    } cmp_op_e;

    typedef enum logic [1:0] {
        rf_alu_out, rf_mem_rdata, rf_u_imm, rf_pc_plus4
    } regfilemux_e;

    typedef enum logic [1:0] {
        mem_byte, mem_half, mem_word
    } mem_size_e;

    typedef enum logic {
        opb_rs2, opb_imm
    } opb_sel_e;

    typedef struct packed {
        logic      read;
        logic      write;
        mem_size_e size;
        logic      uns;      // zero-extend loads
    } cw_mem_t;

    typedef struct packed {
        logic                 regf_we;
        logic [`RV_REG_W-1:0] rd;
        regfilemux_e          rf_sel;
    } cw_wb_t;

    // decoded instruction as handed over by the issuer
    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_REG_W-1:0] rs1_idx;
        logic [`RV_XLEN-1:0]  rs1_data;
        logic [`RV_REG_W-1:0] rs2_idx;
        logic [`RV_XLEN-1:0]  rs2_data;
        logic [`RV_XLEN-1:0]  imm;
        logic [`RV_XLEN-1:0]  u_imm;
        alu_op_e              alu_op;
        opb_sel_e             opb_sel;
        cmp_op_e              cmp_op;
        cw_mem_t              cw_mem;
        cw_wb_t               cw_wb;
    } issue_bundle_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] alu;       // branch target when cmp_op was set
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] u_imm;
        logic                br_en;
        cw_mem_t             cw_mem;
        cw_wb_t              cw_wb;
    } exe_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] alu;
        logic [`RV_XLEN-1:0] rdata;     // aligned and extended load data
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] u_imm;
        cw_wb_t              cw_wb;
    } mem_wb_t;

    // reset payloads, control words inactive
    localparam exe_mem_t exe_mem_rst = '{alu: '0, rs2_data: '0, pc: `RV_RESET_PC,
                                         u_imm: '0, br_en: 1'b0, cw_mem: '0, cw_wb: '0};
    localparam mem_wb_t mem_wb_rst = '{alu: '0, rdata: '0, pc: `RV_RESET_PC,
                                       u_imm: '0, cw_wb: '0};

endpackage : rv32i_pkg

// ==== source/rv32i_settings.svh ====
// width and reset-value macros for the RV32I back end, included by the package and testbench
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// data path and address width
`define RV_XLEN 32

// register index, x0..x31
`define RV_REG_W 5

`define RV_RESET_PC 32'h4000_0000 // pc seen in pipeline regs out of reset

`endif

// ==== source/stage_ctrl.sv ====
// pipeline control that issues the go strobes and stalls issue while a memory access is open
module stage_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic issue_i,
    input  logic mem_busy_i,
    input  logic dmem_resp_i,
    input  logic br_en_i,     // compare result held in EX/MEM
    output logic exe_go_o,
    output logic mem_go_o,
    output logic branch_o,
    output logic ready_o
);

    logic run_q;        // low until the first edge after reset
    logic exmem_new_q;  // EX/MEM was loaded at the last edge

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            run_q       <= 1'b0;
            exmem_new_q <= 1'b0;
        end else begin
            run_q       <= 1'b1;
            exmem_new_q <= exe_go_o;
        end
    end

    assign ready_o  = run_q & ~mem_busy_i;
    assign exe_go_o = issue_i & ready_o;
    // ALU ops move on right away and memory ops on their response
    assign mem_go_o = (exmem_new_q & ~mem_busy_i) | dmem_resp_i;
    assign branch_o = exmem_new_q & br_en_i;

    a_no_issue_in_stall: assert property (
        @(posedge clk) disable iff (rst)
        mem_busy_i |-> !exe_go_o && !mem_go_o
    );

endmodule : stage_ctrl

// ==== source/writeback_stage.sv ====
// writeback stage, picks the register-file data and pulses the write port once per instruction
`include "rv32i_settings.svh"

module writeback_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go_i,       // mem_go
    input  rv32i_pkg::mem_wb_t    memwb_i,
    output logic                  rf_we_o,
    output logic [`RV_REG_W-1:0]  rf_rd_o,
    output logic [`RV_XLEN-1:0]   rf_wdata_o,
    output logic [`RV_XLEN-1:0]   fwd_data_o,
    output rv32i_pkg::cw_wb_t     fwd_cw_o
);
    import rv32i_pkg::*;

    logic                wb_q;  // MEM/WB took a new entry last edge
    logic [`RV_XLEN-1:0] sel_data;

    always_comb begin
        case (memwb_i.cw_wb.rf_sel)
            rf_mem_rdata: sel_data = memwb_i.rdata;
            rf_u_imm:     sel_data = memwb_i.u_imm;
            rf_pc_plus4:  sel_data = memwb_i.pc + `RV_XLEN'd4;
            default:      sel_data = memwb_i.alu;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_q <= 1'b0;
        end else begin
            wb_q <= go_i;
        end
    end

    assign rf_we_o    = wb_q & memwb_i.cw_wb.regf_we & (memwb_i.cw_wb.rd != '0); // x0 stays 0
    assign rf_rd_o    = memwb_i.cw_wb.rd;
    assign rf_wdata_o = sel_data;
    assign fwd_data_o = sel_data;
    assign fwd_cw_o   = memwb_i.cw_wb;

endmodule : writeback_stage

// ==== verilog.f ====
+incdir+source
source/rv32i_pkg.sv
source/pipe_reg.sv
source/exe_stage.sv
source/mem_stage.sv
source/writeback_stage.sv
source/stage_ctrl.sv
source/rv32i_back_end.sv
bench/back_end_tb.sv
